// File: Makefile
# Verilator build and run for the tic-tac-toe referee

VERILATOR ?= verilator
TOP       ?= tictactoe_tb
FILELIST  ?= tictactoe.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert

.PHONY: sim clean

# build, run, and fail unless the pass line shows up in the output
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx 'TEST OK'

clean:
	rm -rf $(OBJ_DIR)

// File: hw/board_store.sv
module board_store import ttt_pkg::*; (
    input  logic   ph1,
    input  logic   rst_n,
    move_if.store  mv,
    output board_t board
);

    // row-major cell number of the addressed cell
    cell_idx_t       cell_idx;
    // row and column both inside the board
    logic            addr_ok;
    // one write enable per cell
    logic [NUM_CELLS-1:0] cell_we;

    // row * 3 + col, all in index width
    assign cell_idx = cell_idx_t'(mv.row) * cell_idx_t'(BOARD_DIM) + cell_idx_t'(mv.col);
    assign addr_ok  = (mv.row < coord_t'(BOARD_DIM)) && (mv.col < coord_t'(BOARD_DIM));

    // an out of range address never reads as occupied
    // turn control rejects it as a code error anyway
    assign mv.occupied = addr_ok && (board[cell_idx] != MARK_NONE);

    // cell registers, each with its own decoded enable
    for (genvar i = 0; i < NUM_CELLS; i++) begin : g_cell
        assign cell_we[i] = mv.commit && addr_ok && (cell_idx == cell_idx_t'(i));

        always_ff @(posedge ph1 or negedge rst_n) begin
            if (!rst_n) begin
                board[i] <= MARK_NONE;
            end else if (cell_we[i]) begin
                // only the addressed cell takes the mark
                board[i] <= mv.mark;
            end
        end
    end

endmodule

// File: hw/cell_scanner.sv
module cell_scanner import ttt_pkg::*; (
    input  logic   ph1,
    input  logic   rst_n,
    input  board_t board,
    output mark_t  mark_out,
    output coord_t row_out,
    output coord_t col_out
);

    // cell currently on the pins, counts 0 to 8
    cell_idx_t scan_idx;

    // free running modulo-nine counter
    always_ff @(posedge ph1 or negedge rst_n) begin
        if (!rst_n) begin
            scan_idx <= '0;
        end else if (scan_idx == cell_idx_t'(NUM_CELLS - 1)) begin
            scan_idx <= '0;
        end else begin
            scan_idx <= scan_idx + 1'b1;
        end
    end

    // split the index back into row and column
    always_comb begin
        if (scan_idx >= cell_idx_t'(2*BOARD_DIM)) begin
            row_out = coord_t'(2);
            col_out = coord_t'(scan_idx - cell_idx_t'(2*BOARD_DIM));
        end else if (scan_idx >= cell_idx_t'(BOARD_DIM)) begin
            row_out = coord_t'(1);
            col_out = coord_t'(scan_idx - cell_idx_t'(BOARD_DIM));
        end else begin
            row_out = coord_t'(0);
            col_out = coord_t'(scan_idx);
        end
    end

    // contents of the scanned cell
    assign mark_out = board[scan_idx];

endmodule

// File: hw/move_if.sv
interface move_if import ttt_pkg::*; ();

    // move fields as offered at the pins
    mark_t  mark;
    coord_t row;
    coord_t col;
    // high when the move passed every check
    logic   commit;
    // addressed cell already holds a mark
    logic   occupied;

    // turn control side, drives the move and reads back occupancy
    modport ctrl (output mark, row, col, commit, input occupied);

    // board side, looks up the cell and stores on commit
    modport store (input mark, row, col, commit, output occupied);

endinterface

// File: hw/tictactoe.sv
module tictactoe import ttt_pkg::*; (
    input  logic       ph1,
    input  logic       rst_n,
    input  logic [1:0] mark_in,
    input  logic [1:0] row_in,
    input  logic [1:0] col_in,
    output logic       err,
    output logic [1:0] mark_out,
    output logic [1:0] row_out,
    output logic [1:0] col_out,
    output logic [1:0] win
);

    // stored board, shared by result logic and scanner
    board_t board;

    // checked move and occupancy answer
    move_if mv ();

    // turn register and move checks
    turn_control u_turn_control (
        .ph1     (ph1),
        .rst_n   (rst_n),
        .mark_in (mark_in),
        .row_in  (row_in),
        .col_in  (col_in),
        .win     (win),
        .mv      (mv.ctrl),
        .err     (err)
    );

    // nine cell registers
    board_store u_board_store (
        .ph1   (ph1),
        .rst_n (rst_n),
        .mv    (mv.store),
        .board (board)
    );

    // line and draw detection, also blocks moves once the game ends
    win_detect u_win_detect (
        .board (board),
        .win   (win)
    );

    // one cell per cycle onto the scan pins
    cell_scanner u_cell_scanner (
        .ph1      (ph1),
        .rst_n    (rst_n),
        .board    (board),
        .mark_out (mark_out),
        .row_out  (row_out),
        .col_out  (col_out)
    );

endmodule

// File: hw/ttt_pkg.sv
package ttt_pkg;

    // board geometry
    localparam int BOARD_DIM = 3;
    localparam int NUM_CELLS = BOARD_DIM * BOARD_DIM;

    // cell contents and move marks share one 2-bit code
    typedef logic [1:0] mark_t;

    // empty cell, or no move offered this cycle
    localparam mark_t MARK_NONE = 2'b00;
    // player o
    localparam mark_t MARK_O = 2'b01;
    // player x, who opens every game
    localparam mark_t MARK_X = 2'b10;
    // never a legal move; on the result pins it flags a draw
    localparam mark_t MARK_BAD = 2'b11;

    // row or column number, legal range 0 to 2
    typedef logic [1:0] coord_t;

    // row-major cell number, row * 3 + col
    typedef logic [3:0] cell_idx_t;

    // all nine cells in one packed word, cell 0 in the low bits
    typedef mark_t [NUM_CELLS-1:0] board_t;

endpackage

// File: hw/turn_control.sv
module turn_control import ttt_pkg::*; (
    input  logic   ph1,
    input  logic   rst_n,
    input  mark_t  mark_in,
    input  coord_t row_in,
    input  coord_t col_in,
    input  mark_t  win,
    move_if.ctrl   mv,
    output logic   err
);

    // high while x is on turn
    logic  x_turn;
    // mark the player on turn is allowed to place
    mark_t turn_mark;
    // any nonzero mark counts as a move attempt
    logic  attempt;
    logic  code_err;
    logic  turn_err;
    logic  over_err;
    // union of all rejection reasons, before qualifying with attempt
    logic  fault;
    logic  commit;

    assign turn_mark = x_turn ? MARK_X : MARK_O;
    assign attempt   = (mark_in != MARK_NONE);

    // 11 is illegal in every field
    assign code_err = (mark_in == MARK_BAD) || (row_in == 2'b11) || (col_in == 2'b11);

    // the other player's mark, out of turn
    assign turn_err = (mark_in != turn_mark);

    // any result, win or draw, ends the game
    assign over_err = (win != MARK_NONE);

    // occupancy comes back from the board in the same cycle
    assign fault = code_err | turn_err | over_err | mv.occupied;

    // nothing is reported while no move is offered
    assign err    = attempt & fault;
    assign commit = attempt & ~fault;

    // offered fields go straight to the board
    assign mv.mark   = mark_in;
    assign mv.row    = row_in;
    assign mv.col    = col_in;
    assign mv.commit = commit;

    // turn register, x opens after reset
    always_ff @(posedge ph1 or negedge rst_n) begin
        if (!rst_n) begin
            x_turn <= 1'b1;
        end else if (commit) begin
            // hand the turn to the other player
            x_turn <= ~x_turn;
        end
    end

endmodule

// File: hw/win_detect.sv
module win_detect import ttt_pkg::*; (
    input  board_t board,
    output mark_t  win
);

    // first completed line found, or none
    mark_t line_win;
    // every cell holds a mark
    logic  full;

    // owner of a line when all three cells match and are not empty
    function automatic mark_t line_owner(input mark_t a, input mark_t b, input mark_t c);
        if ((a != MARK_NONE) && (a == b) && (b == c)) begin
            return a;
        end
        return MARK_NONE;
    endfunction

    always_comb begin
        line_win = MARK_NONE;
        // rows and columns, first hit wins
        for (int i = 0; i < BOARD_DIM; i++) begin
            if (line_win == MARK_NONE) begin
                line_win = line_owner(board[BOARD_DIM*i], board[BOARD_DIM*i + 1],
                                      board[BOARD_DIM*i + 2]);
            end
            if (line_win == MARK_NONE) begin
                line_win = line_owner(board[i], board[BOARD_DIM + i],
                                      board[2*BOARD_DIM + i]);
            end
        end
        // main diagonal, top left to bottom right
        if (line_win == MARK_NONE) begin
            line_win = line_owner(board[0], board[BOARD_DIM + 1], board[NUM_CELLS - 1]);
        end
        // anti diagonal, top right to bottom left
        if (line_win == MARK_NONE) begin
            line_win = line_owner(board[BOARD_DIM - 1], board[BOARD_DIM + 1],
                                  board[2*BOARD_DIM]);
        end
    end

    // draw test, every cell written
    always_comb begin
        full = 1'b1;
        for (int i = 0; i < NUM_CELLS; i++) begin
            full = full & (board[i] != MARK_NONE);
        end
    end

    // a completed line beats a full board
    assign win = (line_win != MARK_NONE) ? line_win : (full ? MARK_BAD : MARK_NONE);

endmodule

// File: tests/tictactoe_checker.sv
module tictactoe_checker import ttt_pkg::*; (
    input logic      ph1,
    input logic      rst_n,
    input logic      commit,
    input logic      err,
    input logic      x_turn,
    input mark_t     mark_in,
    input mark_t     win,
    input cell_idx_t scan_idx
);

    // a stored move is never rejected and comes from the player on turn in an open game
    a_commit_not_err: assert property (
        @(posedge ph1) disable iff (!rst_n)
            commit |-> (!err && (mark_in == (x_turn ? MARK_X : MARK_O))
                        && (win == MARK_NONE))
    ) else $error("commit with err, out of turn, or after the game ended");

    // turn register toggles on a commit edge and holds otherwise
    a_turn_flip: assert property (
        @(posedge ph1) disable iff (!rst_n) (x_turn != $past(x_turn)) == $past(commit)
    ) else $error("turn changed without a commit, or held through one");

    // scanner counts 0 to 8 only
    a_scan_range: assert property (
        @(posedge ph1) disable iff (!rst_n) scan_idx <= cell_idx_t'(NUM_CELLS - 1)
    ) else $error("scan index left the board");

endmodule

// attached at the top level so both the turn logic and the scanner are visible
bind tictactoe tictactoe_checker chk0 (
    .ph1      (ph1),
    .rst_n    (rst_n),
    .commit   (u_turn_control.commit),
    .err      (err),
    .x_turn   (u_turn_control.x_turn),
    .mark_in  (mark_in),
    .win      (win),
    .scan_idx (u_cell_scanner.scan_idx)
);

// File: tests/tictactoe_tb.sv
module tictactoe_tb import ttt_pkg::*; ();

    localparam int          TIMEOUT_CYCLES = 2000;
    localparam int          RANDOM_MOVES   = 60;
    localparam logic [31:0] SEED           = 32'hd92d;

    logic   ph1;
    logic   rst_n;
    mark_t  mark_in;
    coord_t row_in;
    coord_t col_in;
    logic   err;
    mark_t  mark_out;
    coord_t row_out;
    coord_t col_out;
    mark_t  win;

    // reference model of the board and the player on turn
    board_t model_board;
    logic   model_x_turn;

    int errors = 0;
    int passed = 0;
    int failed = 0;
    int cycles = 0;

    // the eight lines as cell numbers, rows then columns then diagonals
    int line_cells [8][3] = '{'{0, 1, 2}, '{3, 4, 5}, '{6, 7, 8},
                              '{0, 3, 6}, '{1, 4, 7}, '{2, 5, 8},
                              '{0, 4, 8}, '{2, 4, 6}};

    tictactoe dut0 (
        .ph1      (ph1),
        .rst_n    (rst_n),
        .mark_in  (mark_in),
        .row_in   (row_in),
        .col_in   (col_in),
        .err      (err),
        .mark_out (mark_out),
        .row_out  (row_out),
        .col_out  (col_out),
        .win      (win)
    );

    always #2 ph1 = ~ph1;

    // run limit, several times the length of all tests
    always @(posedge ph1) begin
        cycles = cycles + 1;
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("timeout: tests did not finish within %0d clock cycles", TIMEOUT_CYCLES);
            $display("TEST FAILED");
            $finish;
        end
    end

    task automatic check_eq(input logic [31:0] got, input logic [31:0] exp, input string msg);
        if (got !== exp) begin
            errors = errors + 1;
            $display("FAILED at %0t: %s, got %0h expected %0h", $time, msg, got, exp);
        end
    endtask

    // game result from the model: a full line of one mark, else a draw on a full board
    function automatic mark_t model_result();
        mark_t a;
        for (int i = 0; i < 8; i++) begin
            a = model_board[line_cells[i][0]];
            if (a != MARK_NONE && a == model_board[line_cells[i][1]]
                    && a == model_board[line_cells[i][2]]) begin
                return a;
            end
        end
        for (int i = 0; i < NUM_CELLS; i++) begin
            if (model_board[i] == MARK_NONE) begin
                return MARK_NONE;
            end
        end
        return MARK_BAD;
    endfunction

    // expected err for an offered move
    function automatic logic predict_err(input mark_t m, input coord_t r, input coord_t c);
        if (m == MARK_NONE) begin
            return 1'b0;
        end
        if (m == MARK_BAD || r == 2'b11 || c == 2'b11) begin
            return 1'b1;
        end
        if (m != (model_x_turn ? MARK_X : MARK_O)) begin
            return 1'b1;
        end
        if (model_result() != MARK_NONE) begin
            return 1'b1;
        end
        return model_board[r * BOARD_DIM + c] != MARK_NONE;
    endfunction

    task automatic do_reset();
        @(negedge ph1);
        rst_n = 1'b0;
        mark_in = MARK_NONE;
        row_in = '0;
        col_in = '0;
        repeat (2) @(negedge ph1);
        rst_n = 1'b1;
        model_board = '0;
        model_x_turn = 1'b1;
    endtask

    // one move held for a single cycle, err checked mid cycle, win after the edge
    task automatic play_move(input mark_t m, input coord_t r, input coord_t c);
        logic exp_err;
        @(negedge ph1);
        mark_in = m;
        row_in = r;
        col_in = c;
        exp_err = predict_err(m, r, c);
        #1;
        check_eq(err, exp_err, $sformatf("err for mark %0d at (%0d,%0d)", m, r, c));
        // no mark offered leaves board and turn alone
        if (m != MARK_NONE && !exp_err) begin
            model_board[r * BOARD_DIM + c] = m;
            model_x_turn = ~model_x_turn;
        end
        @(negedge ph1);
        mark_in = MARK_NONE;
        #1;
        check_eq(win, model_result(), "win after move");
    endtask

    task automatic play_cell(input mark_t m, input int idx);
        play_move(m, coord_t'(idx / BOARD_DIM), coord_t'(idx % BOARD_DIM));
    endtask

    // find cell 0 on the scan pins, then walk all nine cells
    task automatic scan_board(input string tag);
        @(negedge ph1);
        while (!(row_out == 2'd0 && col_out == 2'd0)) begin
            @(negedge ph1);
        end
        for (int i = 0; i < NUM_CELLS; i++) begin
            check_eq(row_out, i / BOARD_DIM, $sformatf("%s scan row, cell %0d", tag, i));
            check_eq(col_out, i % BOARD_DIM, $sformatf("%s scan col, cell %0d", tag, i));
            check_eq(mark_out, model_board[i], $sformatf("%s scan mark, cell %0d", tag, i));
            @(negedge ph1);
        end
    endtask

    task automatic end_test(input string name, input int errs_before);
        if (errors == errs_before) begin
            passed = passed + 1;
            $display("%s: ok", name);
        end else begin
            failed = failed + 1;
            $display("%s: %0d mismatches", name, errors - errs_before);
        end
    endtask

    task automatic test_reset_state();
        int e;
        e = errors;
        do_reset();
        scan_board("reset");
        check_eq(win, MARK_NONE, "win after reset");
        // first x move must go through
        play_cell(MARK_X, 0);
        scan_board("first move");
        end_test("reset_state", e);
    endtask

    task automatic test_rejected_moves();
        int e;
        e = errors;
        do_reset();
        play_cell(MARK_O, 4);
        play_cell(MARK_X, 4);
        play_cell(MARK_X, 0);
        play_move(MARK_O, 2'b11, 2'd1);
        play_move(MARK_O, 2'd1, 2'b11);
        play_move(MARK_BAD, 2'd0, 2'd0);
        // cell 4 already holds x
        play_cell(MARK_O, 4);
        scan_board("rejects");
        end_test("rejected_moves", e);
    endtask

    task automatic test_turn_alternation();
        int e;
        int order [6] = '{4, 0, 8, 2, 1, 7};
        e = errors;
        do_reset();
        for (int i = 0; i < 6; i++) begin
            play_cell((i % 2 == 0) ? MARK_X : MARK_O, order[i]);
            scan_board("alternation");
        end
        end_test("turn_alternation", e);
    endtask

    task automatic test_win_lines();
        int e;
        int others [3];
        int n;
        e = errors;
        for (int l = 0; l < 8; l++) begin
            do_reset();
            // first three cells off the line go to o
            n = 0;
            for (int i = 0; i < NUM_CELLS; i++) begin
                if (n < 3 && i != line_cells[l][0] && i != line_cells[l][1]
                        && i != line_cells[l][2]) begin
                    others[n] = i;
                    n = n + 1;
                end
            end
            play_cell(MARK_X, line_cells[l][0]);
            play_cell(MARK_O, others[0]);
            play_cell(MARK_X, line_cells[l][1]);
            play_cell(MARK_O, others[1]);
            play_cell(MARK_X, line_cells[l][2]);
            check_eq(win, MARK_X, $sformatf("x wins line %0d", l));
            // game is over, o gets no further move
            play_cell(MARK_O, others[2]);
            scan_board("win");
        end
        end_test("win_lines", e);
    endtask

    task automatic test_draw();
        int e;
        int order [9] = '{0, 1, 2, 4, 3, 5, 7, 6, 8};
        e = errors;
        do_reset();
        for (int i = 0; i < NUM_CELLS; i++) begin
            play_cell((i % 2 == 0) ? MARK_X : MARK_O, order[i]);
        end
        check_eq(win, MARK_BAD, "draw on full board");
        play_cell(MARK_O, 0);
        scan_board("draw");
        end_test("draw", e);
    endtask

    task automatic test_random_games();
        int e;
        mark_t  m;
        coord_t r;
        coord_t c;
        e = errors;
        do_reset();
        for (int n = 0; n < RANDOM_MOVES; n++) begin
            if (model_result() != MARK_NONE) begin
                scan_board("random end");
                do_reset();
            end
            // half the moves are on turn and in range, the rest anything
            if ($urandom % 2 == 0) begin
                m = model_x_turn ? MARK_X : MARK_O;
                r = coord_t'($urandom % 3);
                c = coord_t'($urandom % 3);
            end else begin
                m = mark_t'($urandom % 4);
                r = coord_t'($urandom % 4);
                c = coord_t'($urandom % 4);
            end
            play_move(m, r, c);
        end
        scan_board("random");
        end_test("random_games", e);
    endtask

    initial begin
        void'($urandom(SEED));
        ph1 = 1'b0;
        rst_n = 1'b0;
        mark_in = MARK_NONE;
        row_in = '0;
        col_in = '0;
        model_board = '0;
        model_x_turn = 1'b1;
        test_reset_state();
        test_rejected_moves();
        test_turn_alternation();
        test_win_lines();
        test_draw();
        test_random_games();
        $display("tests passed %0d, failed %0d", passed, failed);
        if (failed == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

// File: tictactoe.f
hw/ttt_pkg.sv
hw/move_if.sv
hw/turn_control.sv
hw/board_store.sv
hw/win_detect.sv
hw/cell_scanner.sv
hw/tictactoe.sv
tests/tictactoe_checker.sv
tests/tictactoe_tb.sv
